// ==== build.f ====
common/bp_pkg.sv
hw/branch_decode.sv
predictor/bimodal_table.sv
hw/next_pc_select.sv
hw/bp_stats.sv
hw/branch_predictor_top.sv
tests/tb_branch_predictor.sv

// ==== common/bp_pkg.sv ====
package bp_pkg;

	// Datapath sizes
	localparam int XLEN       = 32;
	localparam int BP_ENTRIES = 128;
	localparam int BP_IDX_W   = $clog2(BP_ENTRIES);  // pc[8:2]
	localparam int BP_TAG_W   = XLEN - BP_IDX_W - 2; // pc[31:9]

	// RV32I conditional branch opcode (BEQ, BNE, BLT, BGE, BLTU, BGEU)
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// Two-bit saturating counter, msb means predict taken
	typedef enum logic [1:0] {
		strong_nt = 2'd0,
		weak_nt   = 2'd1,
		weak_t    = 2'd2,
		strong_t  = 2'd3
	} bp_ctr_t;

	// One fetched instruction from the fetch stage
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
	} fetch_req_t;

	// Resolved branch from execute
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic            taken;
	} bp_update_t;

	typedef struct packed {
		logic            is_branch;
		logic            backward;  // Negative offset
		logic [XLEN-1:0] target;
	} decode_info_t;

	typedef struct packed {
		logic hit;
		logic taken;
	} bp_lookup_t;

	typedef struct packed {
		logic            valid;
		logic            hit;
		logic            taken;
		logic [XLEN-1:0] next_pc;
	} bp_pred_t;

	// Performance counters
	typedef struct packed {
		logic [31:0] pred_taken;
		logic [31:0] pred_not_taken;
		logic [31:0] res_taken;
		logic [31:0] res_not_taken;
	} bp_stats_t;

endpackage

// ==== hw/bp_stats.sv ====
`timescale 1ns/100ps

module bp_stats import bp_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  bp_pred_t   pred_i,
	input  bp_update_t update_i,
	output bp_stats_t  stats_o
);

	bp_stats_t stats_q;
	bp_stats_t stats_d;

	// All counters wrap silently at 2^32
	always_comb begin
		stats_d = stats_q;

		if (pred_i.valid) begin
			if (pred_i.taken) begin
				stats_d.pred_taken = stats_q.pred_taken + 32'd1;
			end else begin
				stats_d.pred_not_taken = stats_q.pred_not_taken + 32'd1;
			end
		end

		// Resolved outcomes from execute
		if (update_i.valid) begin
			if (update_i.taken) begin
				stats_d.res_taken = stats_q.res_taken + 32'd1;
			end else begin
				stats_d.res_not_taken = stats_q.res_not_taken + 32'd1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			stats_q <= '0;
		end else begin
			stats_q <= stats_d;
		end
	end

	assign stats_o = stats_q;  // Visible the cycle after the event

endmodule

// ==== hw/branch_decode.sv ====
`timescale 1ns/100ps

module branch_decode import bp_pkg::*; (
	input  fetch_req_t   fetch_i,
	output decode_info_t dec_o
);

	logic [6:0]      opcode;
	logic [12:0]     b_imm;     // Raw B-type immediate, bit 0 always zero
	logic [XLEN-1:0] b_imm_sx;  // Sign extended to full width
	logic [XLEN-1:0] target;

	assign opcode = fetch_i.instr[6:0];

	// B-type immediate layout
	// imm[12]   <- instr[31]
	// imm[11]   <- instr[7]
	// imm[10:5] <- instr[30:25]
	// imm[4:1]  <- instr[11:8]
	assign b_imm = {
		fetch_i.instr[31],
		fetch_i.instr[7],
		fetch_i.instr[30:25],
		fetch_i.instr[11:8],
		1'b0
	};

	assign b_imm_sx = {{(XLEN-13){b_imm[12]}}, b_imm};

	// Target is pc relative, wraps at the top of the address space
	assign target = fetch_i.pc + b_imm_sx;

	always_comb begin
		dec_o.is_branch = (opcode == OPC_BRANCH);
		dec_o.backward  = b_imm[12];  // Sign bit gives loop direction
		dec_o.target    = target;
	end

endmodule

// ==== hw/branch_predictor_top.sv ====
`timescale 1ns/100ps

module branch_predictor_top import bp_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,

	// From fetch
	input  fetch_req_t fetch_i,

	// From execute, resolved branches
	input  bp_update_t update_i,

	output bp_pred_t   pred_o,
	output bp_stats_t  stats_o
);

	decode_info_t dec;
	bp_lookup_t   lkp;

	// Opcode check and target adder
	branch_decode u_branch_decode (
		.fetch_i (fetch_i),
		.dec_o   (dec)
	);

	// Tagged counter table
	bimodal_table u_bimodal_table (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.fetch_pc_i (fetch_i.pc),
		.update_i   (update_i),
		.lookup_o   (lkp)
	);

	next_pc_select u_next_pc_select (
		.fetch_i  (fetch_i),
		.dec_i    (dec),
		.lookup_i (lkp),
		.pred_o   (pred_o)
	);

	// Counts the final prediction, not the raw lookup
	bp_stats u_bp_stats (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.pred_i   (pred_o),
		.update_i (update_i),
		.stats_o  (stats_o)
	);

endmodule

// ==== hw/next_pc_select.sv ====
`timescale 1ns/100ps

module next_pc_select import bp_pkg::*; (
	input  fetch_req_t   fetch_i,
	input  decode_info_t dec_i,
	input  bp_lookup_t   lookup_i,
	output bp_pred_t     pred_o
);

	logic [XLEN-1:0] seq_pc;      // Fall through address
	logic            is_br;       // Valid conditional branch this cycle
	logic            dir_taken;   // Direction before qualification
	logic            pred_taken;

	assign seq_pc = fetch_i.pc + XLEN'(4);
	assign is_br  = fetch_i.valid & dec_i.is_branch;

	// Table wins on a hit
	// otherwise static BTFN rule, backward taken and forward not taken
	assign dir_taken  = lookup_i.hit ? lookup_i.taken : dec_i.backward;
	assign pred_taken = is_br & dir_taken;

	always_comb begin
		pred_o.valid   = is_br;
		pred_o.hit     = is_br & lookup_i.hit;
		pred_o.taken   = pred_taken;
		pred_o.next_pc = pred_taken ? dec_i.target : seq_pc;
	end

endmodule

// ==== predictor/bimodal_table.sv ====
`timescale 1ns/100ps

module bimodal_table import bp_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic [XLEN-1:0] fetch_pc_i,
	input  bp_update_t      update_i,
	output bp_lookup_t      lookup_o
);

	// Direct mapped storage
	logic [BP_ENTRIES-1:0] valid_q;
	logic [BP_TAG_W-1:0]   tag_q [BP_ENTRIES];
	bp_ctr_t               ctr_q [BP_ENTRIES];

	// Lookup side
	logic [BP_IDX_W-1:0]   lkp_idx;
	logic [BP_TAG_W-1:0]   lkp_tag;
	logic                  lkp_hit;
	bp_ctr_t               lkp_ctr;

	// Update side
	logic [BP_IDX_W-1:0]   upd_idx;
	logic [BP_TAG_W-1:0]   upd_tag;
	logic                  upd_hit;
	bp_ctr_t               upd_ctr;
	bp_ctr_t               ctr_next;

	// Word aligned pc, low two bits dropped
	assign lkp_idx = fetch_pc_i[BP_IDX_W+1:2];
	assign lkp_tag = fetch_pc_i[XLEN-1:BP_IDX_W+2];
	assign upd_idx = update_i.pc[BP_IDX_W+1:2];
	assign upd_tag = update_i.pc[XLEN-1:BP_IDX_W+2];

	// Same cycle lookup, sees state before any update in this cycle
	assign lkp_ctr = ctr_q[lkp_idx];
	assign lkp_hit = valid_q[lkp_idx] && (tag_q[lkp_idx] == lkp_tag);

	always_comb begin
		lookup_o.hit   = lkp_hit;
		lookup_o.taken = lkp_hit & lkp_ctr[1];  // Empty entries read as zero
	end

	assign upd_ctr = ctr_q[upd_idx];
	assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

	// Saturate on a matching entry, otherwise allocate weakly
	always_comb begin
		if (upd_hit) begin
			case (upd_ctr)
				strong_nt: ctr_next = update_i.taken ? weak_nt  : strong_nt;
				weak_nt:   ctr_next = update_i.taken ? weak_t   : strong_nt;
				weak_t:    ctr_next = update_i.taken ? strong_t : weak_nt;
				strong_t:  ctr_next = update_i.taken ? strong_t : weak_t;
				default:   ctr_next = weak_nt;
			endcase
		end else begin
			ctr_next = update_i.taken ? weak_t : weak_nt;
		end
	end

	// Valid bits are the only control state
	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			valid_q <= '0;
		end else if (update_i.valid) begin
			valid_q[upd_idx] <= 1'b1;
		end
	end

	// Tag and counter payload
	always_ff @(posedge clk_i) begin
		if (update_i.valid) begin
			tag_q[upd_idx] <= upd_tag;  // Rewrites same tag on a hit
			ctr_q[upd_idx] <= ctr_next;
		end
	end

endmodule

// ==== tests/tb_branch_predictor.sv ====
`timescale 1ns/100ps

module tb_branch_predictor import bp_pkg::*; ();

	logic       clk_i;
	logic       rst_i;
	fetch_req_t fetch;
	bp_update_t update;
	bp_pred_t   pred;
	bp_stats_t  stats;

	// Expected decode of the fetch on the bus, driven along with it
	logic               exp_br;
	logic signed [12:0] exp_imm;

	// Reference copy of the table
	logic                m_valid [BP_ENTRIES];
	logic [BP_TAG_W-1:0] m_tag [BP_ENTRIES];
	int                  m_ctr [BP_ENTRIES];
	logic [31:0]         m_pt;
	logic [31:0]         m_pnt;
	logic [31:0]         m_rt;
	logic [31:0]         m_rnt;

	logic [31:0] lfsr_q = 32'd80902;
	int          rand_cycles = 400;
	bp_update_t  no_upd = '0;

	branch_predictor_top UUT (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.fetch_i  (fetch),
		.update_i (update),
		.pred_o   (pred),
		.stats_o  (stats)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// Directed part is well under 200 cycles
	initial begin
		#((rand_cycles + 200) * 10);
		$display("Timeout: the test did not finish within the expected number of cycles");
		$display("test failed");
		$fatal(1);
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	// B-type layout, register and funct3 fields random
	function automatic logic [31:0] encode_branch(input logic signed [12:0] imm);
		logic [31:0] f;
		f = rand_bits(13);
		return {imm[12], imm[10:5], f[12:0], imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] other_instr();
		logic [31:0] r;
		r = rand_bits(25);
		return {r[24:0], 7'b0010011};  // OP-IMM
	endfunction

	// Four tags over sixteen sets, so hits and aliasing both occur
	function automatic logic [XLEN-1:0] random_pc();
		logic [31:0] r;
		r = rand_bits(6);
		return 32'h0001_0000 | {r[5:4], 9'b0} | {r[3:0], 2'b00};
	endfunction

	function automatic bp_update_t make_update(input logic [XLEN-1:0] pc, input logic taken);
		bp_update_t u;
		u.valid = 1'b1;
		u.pc    = pc;
		u.taken = taken;
		return u;
	endfunction

	task automatic check_eq(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic drive_cycle(input fetch_req_t f, input logic br,
			input logic signed [12:0] imm, input bp_update_t u);
		@(posedge clk_i);
		fetch   <= f;
		update  <= u;
		exp_br  <= br;
		exp_imm <= imm;
	endtask

	task automatic fetch_branch(input logic [XLEN-1:0] pc, input logic signed [12:0] imm,
			input bp_update_t u);
		fetch_req_t f;
		f.valid = 1'b1;
		f.pc    = pc;
		f.instr = encode_branch(imm);
		drive_cycle(f, 1'b1, imm, u);
	endtask

	task automatic fetch_other(input logic [XLEN-1:0] pc, input bp_update_t u);
		fetch_req_t f;
		f.valid = 1'b1;
		f.pc    = pc;
		f.instr = other_instr();
		drive_cycle(f, 1'b0, '0, u);
	endtask

	task automatic idle_cycle();
		drive_cycle('0, 1'b0, '0, no_upd);
	endtask

	// Mid cycle: compare, then advance the model past the coming edge
	always @(negedge clk_i) begin
		logic [6:0]          idx;
		logic [22:0]         tag;
		logic                hit;
		logic                e_valid;
		logic                e_taken;
		logic [XLEN-1:0]     e_next;
		if (!rst_i) begin
			for (int i = 0; i < BP_ENTRIES; i++)
				m_valid[i] = 1'b0;
			m_pt  = '0;
			m_pnt = '0;
			m_rt  = '0;
			m_rnt = '0;
		end else begin
			idx     = fetch.pc[8:2];
			tag     = fetch.pc[31:9];
			hit     = m_valid[idx] && (m_tag[idx] == tag);
			e_valid = fetch.valid && exp_br;
			e_taken = e_valid && (hit ? (m_ctr[idx] >= 2) : (exp_imm < 0));
			e_next  = e_taken ? fetch.pc + 32'(exp_imm) : fetch.pc + 32'd4;

			check_eq("pred_o.valid", pred.valid, e_valid);
			check_eq("pred_o.hit", pred.hit, e_valid && hit);
			check_eq("pred_o.taken", pred.taken, e_taken);
			check_eq("pred_o.next_pc", pred.next_pc, e_next);
			check_eq("stats_o.pred_taken", stats.pred_taken, m_pt);
			check_eq("stats_o.pred_not_taken", stats.pred_not_taken, m_pnt);
			check_eq("stats_o.res_taken", stats.res_taken, m_rt);
			check_eq("stats_o.res_not_taken", stats.res_not_taken, m_rnt);

			if (e_valid && e_taken) m_pt = m_pt + 1;
			if (e_valid && !e_taken) m_pnt = m_pnt + 1;

			if (update.valid) begin
				idx = update.pc[8:2];
				tag = update.pc[31:9];
				if (update.taken) m_rt = m_rt + 1;
				else m_rnt = m_rnt + 1;
				if (m_valid[idx] && m_tag[idx] == tag) begin
					if (update.taken && m_ctr[idx] < 3) m_ctr[idx]++;
					else if (!update.taken && m_ctr[idx] > 0) m_ctr[idx]--;
				end else begin
					m_valid[idx] = 1'b1;
					m_tag[idx]   = tag;
					m_ctr[idx]   = update.taken ? 2 : 1;
				end
			end
		end
	end

	initial begin
		logic [XLEN-1:0]    pc_a;
		logic [XLEN-1:0]    pc_b;
		logic [XLEN-1:0]    pc_c;
		logic [7:0]         train_seq;
		logic [31:0]        r;
		logic signed [12:0] imm;
		logic               br;
		fetch_req_t         f;
		bp_update_t         u;

		rst_i   = 1'b0;
		fetch   = '0;
		update  = '0;
		exp_br  = 1'b0;
		exp_imm = '0;
		repeat (4) @(posedge clk_i);
		rst_i <= 1'b1;

		fetch_other(32'h0000_1000, no_upd);
		idle_cycle();

		// Cold misses follow the static direction
		fetch_branch(32'h0000_2000, -13'sd64, no_upd);
		fetch_branch(32'h0000_2100, 13'sd256, no_upd);
		fetch_branch(32'h0000_0010, -13'sd2048, no_upd);  // Target wraps below zero

		// t t t n n n n t, hits both saturation ends
		pc_a      = 32'h0000_4040;
		train_seq = 8'b1110_0001;
		for (int i = 0; i < 8; i++) begin
			fetch_branch(pc_a, 13'sd16, make_update(pc_a, train_seq[7-i]));
			fetch_branch(pc_a, 13'sd16, no_upd);
		end

		// Same set, other tag
		pc_b = pc_a ^ 32'h0000_0200;
		fetch_branch(pc_b, -13'sd8, no_upd);
		fetch_branch(pc_b, -13'sd8, make_update(pc_b, 1'b0));
		fetch_branch(pc_a, 13'sd16, no_upd);
		fetch_branch(pc_b, -13'sd8, no_upd);  // weak_nt overrides backward rule

		// Lookup in the update cycle sees the old counter
		pc_c = 32'h0000_6100;
		fetch_branch(pc_c, 13'sd32, make_update(pc_c, 1'b1));
		fetch_branch(pc_c, 13'sd32, make_update(pc_c, 1'b0));
		fetch_branch(pc_c, 13'sd32, no_upd);

		for (int i = 0; i < rand_cycles; i++) begin
			r       = rand_bits(2);
			f.valid = (r[1:0] != 2'b00);
			f.pc    = random_pc();
			r       = rand_bits(12);
			imm     = {r[11:0], 1'b0};
			r       = rand_bits(2);
			br      = (r[1:0] != 2'b00);
			f.instr = br ? encode_branch(imm) : other_instr();
			r       = rand_bits(2);
			u.valid = r[0];
			u.taken = r[1];
			u.pc    = random_pc();
			drive_cycle(f, br, imm, u);
		end
		idle_cycle();
		idle_cycle();

		// Second reset wipes counts and valid bits
		@(posedge clk_i);
		rst_i  <= 1'b0;
		fetch  <= '0;
		update <= '0;
		exp_br <= 1'b0;
		repeat (3) @(posedge clk_i);
		@(posedge clk_i);
		rst_i <= 1'b1;
		fetch_branch(pc_a, 13'sd16, no_upd);
		fetch_branch(pc_b, -13'sd8, no_upd);
		fetch_branch(pc_c, 13'sd32, no_upd);
		idle_cycle();
		@(posedge clk_i);

		$display("test passed");
		$finish;
	end

endmodule
